// File: list.f
+incdir+include
rtl/fetchPkg.sv
rtl/branchTargetBuffer.sv
rtl/nextPcStage.sv
rtl/instCache.sv
rtl/fetchStage.sv
rtl/fetchFrontEnd.sv
test/fetchTb.sv

// File: rtl/branchTargetBuffer.sv
// Direct-mapped branch target buffer
// Two combinational lookups for the lanes of the current group, one write port

`timescale 1ns/1ns

module branchTargetBuffer (
    input  logic            clock,
    input  logic            rstN,
    input  fetchPkg::pcT     curPc,
    input  logic            btbWrite,
    input  fetchPkg::pcT     btbPc,
    input  fetchPkg::pcT     btbTarget,
    output fetchPkg::laneMaskT predHit,
    output fetchPkg::pcT     predTarget0,
    output fetchPkg::pcT     predTarget1
);

    // Entry storage
    logic [fetchPkg::BTB_ENTRIES-1:0] entryValid;
    fetchPkg::tagT entryTag [fetchPkg::BTB_ENTRIES];
    fetchPkg::pcT entryTarget [fetchPkg::BTB_ENTRIES];

    // Per-lane lookup fields
    fetchPkg::pcT lanePc [fetchPkg::FETCH_WIDTH];
    fetchPkg::btbIndexT laneIndex [fetchPkg::FETCH_WIDTH];
    fetchPkg::tagT laneTag [fetchPkg::FETCH_WIDTH];
    fetchPkg::pcT laneTarget [fetchPkg::FETCH_WIDTH];

    // Write side fields
    fetchPkg::btbIndexT writeIndex;
    fetchPkg::tagT writeTag;

    assign writeIndex = btbPc[fetchPkg::BTB_INDEX_LSB +: fetchPkg::BTB_INDEX_BITS];
    assign writeTag = btbPc[fetchPkg::TAG_LSB +: fetchPkg::TAG_BITS];

    // Lookup both words of the aligned group
    always_comb begin
        for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
            lanePc[i] = (curPc & fetchPkg::ALIGN_MASK) + fetchPkg::pcT'(i * fetchPkg::INSN_BYTES);
            laneIndex[i] = lanePc[i][fetchPkg::BTB_INDEX_LSB +: fetchPkg::BTB_INDEX_BITS];
            laneTag[i] = lanePc[i][fetchPkg::TAG_LSB +: fetchPkg::TAG_BITS];
            // Hit needs a live entry with a matching tag
            predHit[i] = entryValid[laneIndex[i]] && (entryTag[laneIndex[i]] == laneTag[i]);
            laneTarget[i] = entryTarget[laneIndex[i]];
        end
    end

    assign predTarget0 = laneTarget[0];
    assign predTarget1 = laneTarget[1];

    // Valid bits only, cleared on reset
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (btbWrite) begin
            entryValid[writeIndex] <= 1'b1;
        end
    end

    // Tag and target replace the old entry
    always_ff @(posedge clock) begin
        if (btbWrite) begin
            entryTag[writeIndex] <= writeTag;
            entryTarget[writeIndex] <= btbTarget;
        end
    end

endmodule

// File: rtl/fetchFrontEnd.sv
// Two-lane instruction fetch front end
// Next-PC stage with BTB prediction feeding a fetch stage with an
// instruction cache and single outstanding refill

`timescale 1ns/1ns

module fetchFrontEnd (
    input  logic               clock,
    input  logic               rstN,
    input  logic               redirect,
    input  fetchPkg::pcT        redirectPc,
    input  logic               btbWrite,
    input  fetchPkg::pcT        btbPc,
    input  fetchPkg::pcT        btbTarget,
    input  logic               memResp,
    input  fetchPkg::lineT      memData,
    output logic               memReq,
    output fetchPkg::pcT        memAddr,
    output fetchPkg::laneMaskT  outValid,
    output fetchPkg::pcT        outPc,
    output fetchPkg::insnT      outInsn0,
    output fetchPkg::insnT      outInsn1,
    output fetchPkg::laneMaskT  outPredTaken,
    output fetchPkg::pcT        outPredTarget
);

    // Next-PC to BTB and fetch stage
    fetchPkg::pcT curPc;
    fetchPkg::laneMaskT curValid;
    fetchPkg::laneMaskT predHit;
    fetchPkg::pcT predTarget0;
    fetchPkg::pcT predTarget1;
    fetchPkg::laneMaskT laneTaken;
    fetchPkg::pcT takenTarget;

    // Fetch stage to cache and back
    logic fetchStall;
    fetchPkg::pcT lookupPc;
    logic hit;
    fetchPkg::lineT lineData;

    nextPcStage nextPcStage_i (
        .clock(clock),
        .rstN(rstN),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .fetchStall(fetchStall),
        .predHit(predHit),
        .predTarget0(predTarget0),
        .predTarget1(predTarget1),
        .curPc(curPc),
        .curValid(curValid),
        .laneTaken(laneTaken),
        .takenTarget(takenTarget)
    );

    branchTargetBuffer branchTargetBuffer_i (
        .clock(clock),
        .rstN(rstN),
        .curPc(curPc),
        .btbWrite(btbWrite),
        .btbPc(btbPc),
        .btbTarget(btbTarget),
        .predHit(predHit),
        .predTarget0(predTarget0),
        .predTarget1(predTarget1)
    );

    fetchStage fetchStage_i (
        .clock(clock),
        .rstN(rstN),
        .redirect(redirect),
        .curPc(curPc),
        .curValid(curValid),
        .laneTaken(laneTaken),
        .takenTarget(takenTarget),
        .hit(hit),
        .lineData(lineData),
        .fetchStall(fetchStall),
        .lookupPc(lookupPc),
        .outValid(outValid),
        .outPc(outPc),
        .outInsn0(outInsn0),
        .outInsn1(outInsn1),
        .outPredTaken(outPredTaken),
        .outPredTarget(outPredTarget)
    );

    instCache instCache_i (
        .clock(clock),
        .rstN(rstN),
        .lookupPc(lookupPc),
        .memResp(memResp),
        .memData(memData),
        .hit(hit),
        .lineData(lineData),
        .memReq(memReq),
        .memAddr(memAddr)
    );

endmodule

// File: rtl/fetchPkg.sv
// Fetch front end shared definitions
// Widths, cache and BTB geometry, address and data types

package fetchPkg;

    // Group geometry
    localparam int FETCH_WIDTH = 2;
    localparam int INSN_BYTES = 4;
    localparam int GROUP_BYTES = FETCH_WIDTH * INSN_BYTES;

    // Data path widths
    localparam int PC_BITS = 32;
    localparam int INSN_BITS = 32;

    // Instruction cache geometry, one group per line
    localparam int IC_LINES = 8;
    localparam int IC_INDEX_LSB = 3;
    localparam int IC_INDEX_BITS = $clog2(IC_LINES);

    // BTB geometry, indexed per instruction word
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_LSB = 2;
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);

    // Tag is shared by cache and BTB
    localparam int TAG_LSB = 6;
    localparam int TAG_BITS = PC_BITS - TAG_LSB;

    typedef logic [PC_BITS-1:0] pcT;
    typedef logic [INSN_BITS-1:0] insnT;
    // Lane 0 sits in the low word
    typedef logic [FETCH_WIDTH*INSN_BITS-1:0] lineT;
    typedef logic [FETCH_WIDTH-1:0] laneMaskT;
    typedef logic [TAG_BITS-1:0] tagT;
    typedef logic [IC_INDEX_BITS-1:0] icIndexT;
    typedef logic [BTB_INDEX_BITS-1:0] btbIndexT;

    // Clears the offset inside a fetch group
    localparam pcT ALIGN_MASK = ~pcT'(GROUP_BYTES - 1);

endpackage

// File: rtl/fetchStage.sv
// Fetch stage
// Pipeline register between next-PC and output, stall on cache miss,
// drop of lanes behind a predicted-taken lane, output group formation

`timescale 1ns/1ns

module fetchStage (
    input  logic               clock,
    input  logic               rstN,
    input  logic               redirect,
    input  fetchPkg::pcT        curPc,
    input  fetchPkg::laneMaskT  curValid,
    input  fetchPkg::laneMaskT  laneTaken,
    input  fetchPkg::pcT        takenTarget,
    input  logic               hit,
    input  fetchPkg::lineT      lineData,
    output logic               fetchStall,
    output fetchPkg::pcT        lookupPc,
    output fetchPkg::laneMaskT  outValid,
    output fetchPkg::pcT        outPc,
    output fetchPkg::insnT      outInsn0,
    output fetchPkg::insnT      outInsn1,
    output fetchPkg::laneMaskT  outPredTaken,
    output fetchPkg::pcT        outPredTarget
);

    // Pipeline register
    fetchPkg::laneMaskT regValid;
    fetchPkg::laneMaskT regTaken;
    fetchPkg::pcT regPc;
    fetchPkg::pcT regTarget;

    // Load side
    fetchPkg::laneMaskT loadMask;
    logic dropLater;
    logic loadEn;

    // Lanes behind the first taken lane never enter the register
    always_comb begin
        loadMask = curValid;
        dropLater = 1'b0;
        for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
            if (dropLater) begin
                loadMask[i] = 1'b0;
            end
            if (laneTaken[i]) begin
                dropLater = 1'b1;
            end
        end
    end

    // Occupied register waiting on the cache
    assign fetchStall = (regValid != '0) && !hit;
    assign loadEn = !redirect && !fetchStall;

    // Control part of the register
    // regPc also drives the cache lookup, so it starts at a known line
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            regValid <= '0;
            regTaken <= '0;
            regPc <= '0;
        end else if (redirect) begin
            // Flush, address kept so a pending refill still matches
            regValid <= '0;
            regTaken <= '0;
        end else if (loadEn) begin
            regValid <= loadMask;
            regTaken <= laneTaken;
            regPc <= curPc & fetchPkg::ALIGN_MASK;
        end
    end

    // Predicted target travels with the group
    always_ff @(posedge clock) begin
        if (loadEn) begin
            regTarget <= takenTarget;
        end
    end

    assign lookupPc = regPc;

    // Group shown only once the line is present
    assign outValid = regValid & {fetchPkg::FETCH_WIDTH{hit}};
    assign outPredTaken = regTaken & outValid;
    assign outPc = regPc;
    assign outPredTarget = regTarget;

    // Lane 0 in the low word of the line
    assign outInsn0 = lineData[0 +: fetchPkg::INSN_BITS];
    assign outInsn1 = lineData[fetchPkg::INSN_BITS +: fetchPkg::INSN_BITS];

endmodule

// File: rtl/instCache.sv
// Direct-mapped instruction cache, one fetch group per line
// Hit check against the fetch register's address and single refill tracking
// Refill requests are one-cycle pulses, responses write the stored line slot

`timescale 1ns/1ns

module instCache (
    input  logic           clock,
    input  logic           rstN,
    input  fetchPkg::pcT    lookupPc,
    input  logic           memResp,
    input  fetchPkg::lineT  memData,
    output logic           hit,
    output fetchPkg::lineT  lineData,
    output logic           memReq,
    output fetchPkg::pcT    memAddr
);

    // Line storage
    fetchPkg::lineT lineStore [fetchPkg::IC_LINES];
    fetchPkg::tagT tagStore [fetchPkg::IC_LINES];
    logic [fetchPkg::IC_LINES-1:0] lineValid;

    // Refill tracking
    logic pending;
    logic missStart;
    fetchPkg::pcT refillPc;
    fetchPkg::icIndexT refillIndex;
    fetchPkg::tagT refillTag;

    // Lookup fields
    fetchPkg::icIndexT lookupIndex;
    fetchPkg::tagT lookupTag;

    assign lookupIndex = lookupPc[fetchPkg::IC_INDEX_LSB +: fetchPkg::IC_INDEX_BITS];
    assign lookupTag = lookupPc[fetchPkg::TAG_LSB +: fetchPkg::TAG_BITS];

    assign hit = lineValid[lookupIndex] && (tagStore[lookupIndex] == lookupTag);
    assign lineData = lineStore[lookupIndex];

    // Slot and tag come from the request, not the current lookup
    // so a redirect in between cannot misplace the line
    assign refillIndex = refillPc[fetchPkg::IC_INDEX_LSB +: fetchPkg::IC_INDEX_BITS];
    assign refillTag = refillPc[fetchPkg::TAG_LSB +: fetchPkg::TAG_BITS];
    assign memAddr = refillPc;

    // New refill only when nothing is outstanding
    assign missStart = !hit && !pending && !memResp;

    // Valid bits, pending flag and request pulse
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            lineValid <= '0;
            pending <= 1'b0;
            memReq <= 1'b0;
        end else begin
            // Request lasts one cycle
            memReq <= 1'b0;
            if (memResp) begin
                lineValid[refillIndex] <= 1'b1;
                pending <= 1'b0;
            end else if (missStart) begin
                pending <= 1'b1;
                memReq <= 1'b1;
            end
        end
    end

    // Line address latched with the request
    always_ff @(posedge clock) begin
        if (missStart) begin
            refillPc <= lookupPc & fetchPkg::ALIGN_MASK;
        end
    end

    // Line data and tag written at the response edge
    always_ff @(posedge clock) begin
        if (memResp) begin
            lineStore[refillIndex] <= memData;
            tagStore[refillIndex] <= refillTag;
        end
    end

endmodule

// File: rtl/nextPcStage.sv
// Next-PC stage
// Holds the fetch address, picks the first predicted-taken lane and
// selects the following fetch address

`timescale 1ns/1ns

module nextPcStage (
    input  logic               clock,
    input  logic               rstN,
    input  logic               redirect,
    input  fetchPkg::pcT        redirectPc,
    input  logic               fetchStall,
    input  fetchPkg::laneMaskT  predHit,
    input  fetchPkg::pcT        predTarget0,
    input  fetchPkg::pcT        predTarget1,
    output fetchPkg::pcT        curPc,
    output fetchPkg::laneMaskT  curValid,
    output fetchPkg::laneMaskT  laneTaken,
    output fetchPkg::pcT        takenTarget
);

    fetchPkg::pcT pcReg;
    fetchPkg::pcT alignedPc;
    fetchPkg::pcT nextPc;

    assign curPc = pcReg;
    assign alignedPc = pcReg & fetchPkg::ALIGN_MASK;

    // Lanes at or after the fetch address are live
    // An entry into the upper word leaves lane 0 dead
    always_comb begin
        for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
            curValid[i] = (alignedPc + fetchPkg::pcT'(i * fetchPkg::INSN_BYTES)) >= pcReg;
        end
    end

    // Only the first live hit counts
    always_comb begin
        laneTaken = '0;
        for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
            if (curValid[i] && predHit[i] && (laneTaken == '0)) begin
                laneTaken[i] = 1'b1;
            end
        end
    end

    assign takenTarget = laneTaken[0] ? predTarget0 : predTarget1;

    // Redirect beats stall, stall beats prediction
    always_comb begin
        if (redirect) begin
            nextPc = redirectPc;
        end else if (fetchStall) begin
            nextPc = pcReg;
        end else if (laneTaken != '0) begin
            nextPc = takenTarget;
        end else begin
            nextPc = alignedPc + fetchPkg::pcT'(fetchPkg::GROUP_BYTES);
        end
    end

    // Fetch starts at address 0 out of reset
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pcReg <= '0;
        end else begin
            pcReg <= nextPc;
        end
    end

endmodule

// File: include/fetchTbModel.svh
// Reference model for the fetch front end testbench
// Memory contents, BTB and cache mirrors, expected group stream, compare tasks

`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

// BTB and cache mirrors, indexed like the design
logic modelBtbValid [fetchPkg::BTB_ENTRIES];
fetchPkg::tagT modelBtbTag [fetchPkg::BTB_ENTRIES];
fetchPkg::pcT modelBtbTarget [fetchPkg::BTB_ENTRIES];
logic modelLineValid [fetchPkg::IC_LINES];
fetchPkg::tagT modelLineTag [fetchPkg::IC_LINES];

// Fetch address of the next expected group
fetchPkg::pcT expPc;

// Each word is its own address with a fixed pattern mixed in
function automatic fetchPkg::insnT memWord(input fetchPkg::pcT addr);
    return addr ^ 32'h5a5a_0000;
endfunction

// Lane 0 in the low word
function automatic fetchPkg::lineT lineFor(input fetchPkg::pcT addr);
    return {memWord(addr + fetchPkg::INSN_BYTES), memWord(addr)};
endfunction

function automatic fetchPkg::tagT tagOf(input fetchPkg::pcT addr);
    return addr[fetchPkg::TAG_LSB +: fetchPkg::TAG_BITS];
endfunction

// BTB indexed per word, cache per group
function automatic fetchPkg::btbIndexT btbSlot(input fetchPkg::pcT addr);
    return addr[fetchPkg::BTB_INDEX_LSB +: fetchPkg::BTB_INDEX_BITS];
endfunction

function automatic fetchPkg::icIndexT lineSlot(input fetchPkg::pcT addr);
    return addr[fetchPkg::IC_INDEX_LSB +: fetchPkg::IC_INDEX_BITS];
endfunction

task automatic resetModel();
    for (int i = 0; i < fetchPkg::BTB_ENTRIES; i++) begin
        modelBtbValid[i] = 1'b0;
        modelBtbTag[i] = '0;
        modelBtbTarget[i] = '0;
    end
    for (int i = 0; i < fetchPkg::IC_LINES; i++) begin
        modelLineValid[i] = 1'b0;
        modelLineTag[i] = '0;
    end
    // Fetch starts at address 0
    expPc = '0;
endtask

task automatic writeBtbModel(input fetchPkg::pcT branchPc, input fetchPkg::pcT target);
    modelBtbValid[btbSlot(branchPc)] = 1'b1;
    modelBtbTag[btbSlot(branchPc)] = tagOf(branchPc);
    modelBtbTarget[btbSlot(branchPc)] = target;
endtask

task automatic refillModel(input fetchPkg::pcT addr);
    modelLineValid[lineSlot(addr)] = 1'b1;
    modelLineTag[lineSlot(addr)] = tagOf(addr);
endtask

function automatic logic lineCached(input fetchPkg::pcT addr);
    return modelLineValid[lineSlot(addr)] && (modelLineTag[lineSlot(addr)] == tagOf(addr));
endfunction

// Next group of the stream, then step the fetch address
task automatic takeExpectedGroup(output fetchPkg::pcT aligned, output fetchPkg::laneMaskT valid,
                                 output fetchPkg::laneMaskT taken, output fetchPkg::pcT target);
    fetchPkg::pcT lanePc;
    fetchPkg::btbIndexT slot;
    aligned = expPc & ~fetchPkg::pcT'(fetchPkg::GROUP_BYTES - 1);
    valid = '0;
    taken = '0;
    target = '0;
    for (int i = 0; i < fetchPkg::FETCH_WIDTH; i++) begin
        lanePc = aligned + fetchPkg::pcT'(i * fetchPkg::INSN_BYTES);
        slot = btbSlot(lanePc);
        // Lanes below the fetch address or behind a taken lane stay empty
        if ((lanePc >= expPc) && (taken == '0)) begin
            valid[i] = 1'b1;
            if (modelBtbValid[slot] && (modelBtbTag[slot] == tagOf(lanePc))) begin
                taken[i] = 1'b1;
                target = modelBtbTarget[slot];
            end
        end
    end
    expPc = (taken != '0) ? target : aligned + fetchPkg::pcT'(fetchPkg::GROUP_BYTES);
endtask

task automatic checkPc(input string name, input fetchPkg::pcT got, input fetchPkg::pcT exp);
    if (got !== exp) begin
        abortRun($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic checkMask(input string name, input fetchPkg::laneMaskT got,
                         input fetchPkg::laneMaskT exp);
    if (got !== exp) begin
        abortRun($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic checkInsn(input string name, input fetchPkg::insnT got, input fetchPkg::insnT exp);
    if (got !== exp) begin
        abortRun($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

`endif

// File: test/fetchTb.sv
// Testbench for the two-lane fetch front end
// LFSR driven redirects and BTB writes, memory responder with random latency,
// output stream and refill requests checked against a reference model

`timescale 1ns/1ns

module fetchTb;

    localparam int HALF_PERIOD = 50;
    localparam int NUM_GROUPS = 400;
    // Room per group for a full refill plus a pipeline restart
    localparam int CYCLES_PER_GROUP = 20;
    localparam int MAX_CYCLES = NUM_GROUPS * CYCLES_PER_GROUP;
    localparam logic [31:0] SEED = 32'hba6e_bb3a;
    // Redirects and BTB entries stay inside a 256-byte window
    localparam fetchPkg::pcT WINDOW_BASE = 32'h0000_0000;
    localparam int WINDOW_WORD_BITS = 6;

    // DUT inputs
    logic clock;
    logic rstN;
    logic redirect;
    fetchPkg::pcT redirectPc;
    logic btbWrite;
    fetchPkg::pcT btbPc;
    fetchPkg::pcT btbTarget;
    logic memResp;
    fetchPkg::lineT memData;

    // DUT outputs
    logic memReq;
    fetchPkg::pcT memAddr;
    fetchPkg::laneMaskT outValid;
    fetchPkg::pcT outPc;
    fetchPkg::insnT outInsn0;
    fetchPkg::insnT outInsn1;
    fetchPkg::laneMaskT outPredTaken;
    fetchPkg::pcT outPredTarget;

    // Responder state and run counters
    logic [31:0] lfsrState;
    logic refillPending;
    fetchPkg::pcT refillAddr;
    int respWait;
    int cycleCount;
    int groupCount;
    int takenCount;
    int redirectsDuringRefill;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "fetchTbModel.svh"

    fetchFrontEnd fetchFrontEnd_i (
        .clock(clock),
        .rstN(rstN),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .btbWrite(btbWrite),
        .btbPc(btbPc),
        .btbTarget(btbTarget),
        .memResp(memResp),
        .memData(memData),
        .memReq(memReq),
        .memAddr(memAddr),
        .outValid(outValid),
        .outPc(outPc),
        .outInsn0(outInsn0),
        .outInsn1(outInsn1),
        .outPredTaken(outPredTaken),
        .outPredTarget(outPredTarget)
    );

    always #HALF_PERIOD clock = ~clock;

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // Word-aligned address inside the window
    function automatic fetchPkg::pcT windowAddr();
        return WINDOW_BASE + fetchPkg::pcT'(randomBits(WINDOW_WORD_BITS)) * fetchPkg::INSN_BYTES;
    endfunction

    // Output group against the next expected group
    task automatic checkOutput();
        fetchPkg::pcT expAligned;
        fetchPkg::laneMaskT expValid;
        fetchPkg::laneMaskT expTaken;
        fetchPkg::pcT expTarget;
        if (outValid != '0) begin
            takeExpectedGroup(expAligned, expValid, expTaken, expTarget);
            checkPc("outPc", outPc, expAligned);
            checkMask("outValid", outValid, expValid);
            checkMask("outPredTaken", outPredTaken, expTaken);
            if (expTaken != '0) begin
                checkPc("outPredTarget", outPredTarget, expTarget);
                takenCount++;
            end
            if (expValid[0]) begin
                checkInsn("outInsn0", outInsn0, memWord(expAligned));
            end
            if (expValid[1]) begin
                checkInsn("outInsn1", outInsn1, memWord(expAligned + fetchPkg::INSN_BYTES));
            end
            if (!lineCached(expAligned)) begin
                abortRun($sformatf("group %h shown before its line was refilled", expAligned));
            end
            groupCount++;
        end
    endtask

    // Refill requests are checked before the response countdown
    task automatic serviceMemory();
        memResp = 1'b0;
        if (memReq) begin
            if (refillPending) begin
                abortRun("memReq raised while a refill was still pending");
            end
            // Refill address points at the start of a line
            checkPc("memAddr offset", memAddr & fetchPkg::pcT'(fetchPkg::GROUP_BYTES - 1), '0);
            if (lineCached(memAddr)) begin
                abortRun($sformatf("memReq for line %h which is already cached", memAddr));
            end
            refillPending = 1'b1;
            refillAddr = memAddr;
            // 1 to 8 cycles after the request edge
            respWait = int'(randomBits(3)) + 1;
        end
        if (refillPending) begin
            respWait--;
            if (respWait == 0) begin
                memResp = 1'b1;
                memData = lineFor(refillAddr);
                refillModel(refillAddr);
                refillPending = 1'b0;
            end
        end
    endtask

    task automatic driveStimulus();
        redirect = 1'b0;
        btbWrite = 1'b0;
        // About one redirect in 16 cycles
        if (randomBits(4) == 0) begin
            redirect = 1'b1;
            redirectPc = windowAddr();
            if (refillPending) begin
                redirectsDuringRefill++;
            end
            // Half of them also write a BTB entry
            if (randomBits(1) == 1) begin
                btbWrite = 1'b1;
                btbPc = windowAddr();
                btbTarget = windowAddr();
                writeBtbModel(btbPc, btbTarget);
            end
            // Groups shown up to now belong to the old stream
            expPc = redirectPc;
        end
    endtask

    initial begin
        clock = 1'b0;
        rstN = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        btbWrite = 1'b0;
        btbPc = '0;
        btbTarget = '0;
        memResp = 1'b0;
        memData = '0;
        lfsrState = SEED;
        refillPending = 1'b0;
        refillAddr = '0;
        respWait = 0;
        cycleCount = 0;
        groupCount = 0;
        takenCount = 0;
        redirectsDuringRefill = 0;
        resetModel();

        // Four cycles in reset with release on a falling edge
        repeat (4) @(posedge clock);
        @(negedge clock);
        checkMask("outValid", outValid, '0);
        if (memReq !== 1'b0) begin
            abortRun("memReq is high during reset");
        end
        rstN = 1'b1;

        while (groupCount < NUM_GROUPS) begin
            @(negedge clock);
            cycleCount++;
            if (cycleCount > MAX_CYCLES) begin
                abortRun($sformatf("timeout after %0d cycles with %0d of %0d groups seen",
                                   cycleCount, groupCount, NUM_GROUPS));
            end
            checkOutput();
            serviceMemory();
            driveStimulus();
        end

        $display("%0d groups in %0d cycles, %0d taken, %0d redirects during a refill",
                 groupCount, cycleCount, takenCount, redirectsDuringRefill);
        if (takenCount == 0) begin
            abortRun("run ended without a predicted-taken group");
        end else if (redirectsDuringRefill == 0) begin
            abortRun("run ended without a redirect during a pending refill");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
